/* sim/cpu_vectors.txt */
# P <byte address> <instruction word>, all hex
# W <rd> <expected write data>, all hex, in retirement order
P 00 00500093  addi x1, x0, 5
P 04 00708113  addi x2, x1, 7
P 08 002081B3  add  x3, x1, x2
P 0C 40118233  sub  x4, x3, x1
P 10 FF000293  addi x5, x0, -16
P 14 0032F333  and  x6, x5, x3
P 18 0012E3B3  or   x7, x5, x1
P 1C 0023C433  xor  x8, x7, x2
P 20 0012A4B3  slt  x9, x5, x1
P 24 00909533  sll  x10, x1, x9
P 28 0092D5B3  srl  x11, x5, x9
P 2C 4092D633  sra  x12, x5, x9
P 30 0F03F693  andi x13, x7, 0xf0
P 34 1000E713  ori  x14, x1, 0x100
P 38 FFF14793  xori x15, x2, -1
P 3C 00D12813  slti x16, x2, 13
P 40 00409893  slli x17, x1, 4
P 44 0042D913  srli x18, x5, 4
P 48 4042D993  srai x19, x5, 4
P 4C 12345A37  lui  x20, 0x12345
P 50 00108013  addi x0, x1, 1
P 54 00100AB3  add  x21, x0, x1
P 58 01508663  beq  x1, x21, +12
P 5C 7FF00B13  addi x22, x0, 0x7ff
P 60 7FF00B93  addi x23, x0, 0x7ff
P 64 00209663  bne  x1, x2, +12
P 68 7FF00B13  addi x22, x0, 0x7ff
P 6C 7FF00B93  addi x23, x0, 0x7ff
P 70 0012C663  blt  x5, x1, +12
P 74 7FF00B13  addi x22, x0, 0x7ff
P 78 7FF00B93  addi x23, x0, 0x7ff
P 7C 0050D663  bge  x1, x5, +12
P 80 7FF00B13  addi x22, x0, 0x7ff
P 84 7FF00B93  addi x23, x0, 0x7ff
P 88 00208663  beq  x1, x2, +12
P 8C 00100B13  addi x22, x0, 1
P 90 00C00C6F  jal  x24, +12
P 94 7FF00B13  addi x22, x0, 0x7ff
P 98 7FF00B93  addi x23, x0, 0x7ff
P 9C 015C0CE7  jalr x25, 21(x24)
P A0 7FF00B13  addi x22, x0, 0x7ff
P A4 7FF00B93  addi x23, x0, 0x7ff
P A8 018C8D33  add  x26, x25, x24
P AC 0000006F  jal  x0, 0
P B0 7FF00B13  addi x22, x0, 0x7ff
W 01 00000005
W 02 0000000C
W 03 00000011
W 04 0000000C
W 05 FFFFFFF0
W 06 00000010
W 07 FFFFFFF5
W 08 FFFFFFF9
W 09 00000001
W 0A 0000000A
W 0B 7FFFFFF8
W 0C FFFFFFF8
W 0D 000000F0
W 0E 00000105
W 0F FFFFFFF3
W 10 00000001
W 11 00000050
W 12 0FFFFFFF
W 13 FFFFFFFF
W 14 12345000
W 15 00000005
W 16 00000001
W 18 00000094
W 19 000000A0
W 1A 00000134

/* cpu_top.f */
logic/core_pkg.sv
logic/ifu.sv
logic/gpr.sv
logic/idu.sv
logic/exu.sv
logic/cpu_top.sv
sim/tb_clk_gen.sv
sim/cpu_top_tb.sv

/* Makefile */
# Verilator build, run, lint and clean for the rv32i core

TOP := cpu_top_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f cpu_top.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Testbench passed" sim.log

lint:
	verilator --lint-only --timing -Wall -f cpu_top.f --top-module cpu_top

clean:
	rm -rf obj_dir sim.log

/* sim/cpu_top_tb.sv */
//**************************************************************************
// rv32i core testbench
// models the synchronous instruction memory from the vector file, checks
// every register write against the expected retirement order and then
// watches the final self loop for stray writes
//**************************************************************************
`timescale 1ns/1ps

module cpu_top_tb;

    import core_pkg::*;

    localparam xlen_t RESET_ADDR  = 32'h0000_0000;
    localparam int    WAIT_LIMIT  = 50;
    localparam int    IDLE_CYCLES = 30;

    logic      clk;
    logic      arst_n_i = 1'b0;
    xlen_t     inst_i   = INST_NOP;
    xlen_t     inst_addr_o;
    logic      wb_we_o;
    reg_addr_t wb_waddr_o;
    xlen_t     wb_wdata_o;

    xlen_t     prog_mem [xlen_t];  // sparse program image
    reg_addr_t exp_rd   [$];
    xlen_t     exp_val  [$];

    tb_clk_gen #(
        .PERIOD_NS(20.0)
    ) u_clk_gen (
        .clk_o(clk)
    );

    cpu_top #(
        .RESET_ADDR(RESET_ADDR)
    ) uut (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .inst_i     (inst_i),
        .inst_addr_o(inst_addr_o),
        .wb_we_o    (wb_we_o),
        .wb_waddr_o (wb_waddr_o),
        .wb_wdata_o (wb_wdata_o)
    );

    function automatic xlen_t fetch_word(input xlen_t addr);
        if (prog_mem.exists(addr)) begin
            return prog_mem[addr];
        end
        return INST_NOP;  // nothing loaded here
    endfunction

    // one cycle read latency, like a synchronous ram
    always @(posedge clk) begin
        inst_i <= fetch_word(inst_addr_o);
    end

    task automatic fail_run(input string why);
        $display("ERROR: %s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input xlen_t expected, input xlen_t actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %08h actual %08h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "run stopped");
        end
    endtask

    task automatic load_vectors();
        int    fd;
        int    n;
        string line;
        string rest;
        xlen_t a;
        xlen_t b;
        fd = $fopen("sim/cpu_vectors.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open sim/cpu_vectors.txt");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 2 && (line[0] == "P" || line[0] == "W")) begin
                rest = line.substr(1, line.len() - 1);
                if ($sscanf(rest, "%h %h", a, b) != 2) begin
                    fail_run("badly formed line in the vector file");
                end
                if (line[0] == "P") begin
                    prog_mem[a] = b;
                end else begin
                    exp_rd.push_back(reg_addr_t'(a));
                    exp_val.push_back(b);
                end
            end
        end
        $fclose(fd);
        if (exp_rd.size() == 0 || prog_mem.num() == 0) begin
            fail_run("vector file holds no program or no expected writes");
        end
    endtask

    // next cycle with a register write, sampled mid cycle
    task automatic wait_writeback();
        int    cycles;
        inst_u cur;
        cycles = 0;
        @(negedge clk);
        while (!wb_we_o) begin
            if (cycles == WAIT_LIMIT) begin
                cur = inst_u'(fetch_word(inst_addr_o));
                $display("fetch at %08h holds opcode %02h rd x%0d rs1 x%0d",
                         inst_addr_o, cur.r.opcode, cur.r.rd, cur.r.rs1);
                fail_run("no register write seen within 50 cycles");
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    initial begin
        int unsigned seed_val;
        int          idle;
        seed_val = $urandom(32'h2f78_b4ce);  // seeds the generator once
        load_vectors();

        // reset for three cycles, fetch parked at the reset address
        repeat (3) begin
            @(negedge clk);
            check_value("inst_addr_o", RESET_ADDR, inst_addr_o);
            check_value("wb_we_o", 32'h0, xlen_t'(wb_we_o));
        end
        @(posedge clk);
        arst_n_i <= 1'b1;
        @(negedge clk);
        check_value("inst_addr_o", RESET_ADDR, inst_addr_o);  // first fetch

        for (int k = 0; k < exp_rd.size(); k++) begin
            wait_writeback();
            check_value("wb_waddr_o", xlen_t'(exp_rd[k]), xlen_t'(wb_waddr_o));
            check_value("wb_wdata_o", exp_val[k], wb_wdata_o);
        end

        // program ends in jal x0, 0 so nothing else retires
        idle = IDLE_CYCLES + int'($urandom % 8);
        repeat (idle) begin
            @(negedge clk);
            check_value("wb_we_o", 32'h0, xlen_t'(wb_we_o));
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

/* sim/tb_clk_gen.sv */
//**************************************************************************
// testbench clock generator
// free running clock, 50 percent duty cycle, starting low
//**************************************************************************
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS = 20.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk_o = ~clk_o;
        end
    end

endmodule

/* logic/cpu_top.sv */
//**************************************************************************
// rv32i core top level
// three stage pipeline of fetch, decode and execute/writeback around the
// register file
//**************************************************************************
`timescale 1ns/1ps

module cpu_top #(
    parameter core_pkg::xlen_t RESET_ADDR = '0
) (
    input  logic                clk,
    input  logic                arst_n_i,
    input  core_pkg::xlen_t     inst_i,
    output core_pkg::xlen_t     inst_addr_o,
    output logic                wb_we_o,
    output core_pkg::reg_addr_t wb_waddr_o,
    output core_pkg::xlen_t     wb_wdata_o
);

    import core_pkg::*;

    // fetch to decode
    logic      if_inst_valid;
    xlen_t     if_inst_pc;

    // decode and register file
    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    xlen_t     rf_rdata1;
    xlen_t     rf_rdata2;

    // decode/execute register
    logic      id_valid;
    xlen_t     id_pc;
    reg_addr_t id_rs1;
    reg_addr_t id_rs2;
    xlen_t     id_rs1_data;
    xlen_t     id_rs2_data;
    xlen_t     id_imm;
    logic      id_use_imm;
    alu_op_e   id_alu_op;
    br_kind_e  id_br_kind;
    reg_addr_t id_rd;
    logic      id_rd_we;

    // execute outputs
    logic      ex_jump;
    xlen_t     ex_jump_addr;
    logic      ex_we;
    reg_addr_t ex_waddr;
    xlen_t     ex_wdata;

    ifu #(
        .RESET_ADDR(RESET_ADDR)
    ) u_ifu (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .jump_i      (ex_jump),
        .jump_addr_i (ex_jump_addr),
        .inst_addr_o (inst_addr_o),
        .inst_pc_o   (if_inst_pc),
        .inst_valid_o(if_inst_valid)
    );

    idu u_idu (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .inst_i       (inst_u'(inst_i)),
        .inst_pc_i    (if_inst_pc),
        .inst_valid_i (if_inst_valid),
        .jump_i       (ex_jump),
        .rs1_rdata_i  (rf_rdata1),
        .rs2_rdata_i  (rf_rdata2),
        .rs1_raddr_o  (rf_raddr1),
        .rs2_raddr_o  (rf_raddr2),
        .id_valid_o   (id_valid),
        .id_pc_o      (id_pc),
        .id_rs1_o     (id_rs1),
        .id_rs2_o     (id_rs2),
        .id_rs1_data_o(id_rs1_data),
        .id_rs2_data_o(id_rs2_data),
        .id_imm_o     (id_imm),
        .id_use_imm_o (id_use_imm),
        .id_alu_op_o  (id_alu_op),
        .id_br_kind_o (id_br_kind),
        .id_rd_o      (id_rd),
        .id_rd_we_o   (id_rd_we)
    );

    exu u_exu (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .id_valid_i   (id_valid),
        .id_pc_i      (id_pc),
        .id_rs1_i     (id_rs1),
        .id_rs2_i     (id_rs2),
        .id_rs1_data_i(id_rs1_data),
        .id_rs2_data_i(id_rs2_data),
        .id_imm_i     (id_imm),
        .id_use_imm_i (id_use_imm),
        .id_alu_op_i  (id_alu_op),
        .id_br_kind_i (id_br_kind),
        .id_rd_i      (id_rd),
        .id_rd_we_i   (id_rd_we),
        .jump_o       (ex_jump),
        .jump_addr_o  (ex_jump_addr),
        .wb_we_o      (ex_we),
        .wb_waddr_o   (ex_waddr),
        .wb_wdata_o   (ex_wdata)
    );

    gpr u_gpr (
        .clk     (clk),
        .arst_n_i(arst_n_i),
        .we_i    (ex_we),
        .waddr_i (ex_waddr),
        .wdata_i (ex_wdata),
        .raddr1_i(rf_raddr1),
        .raddr2_i(rf_raddr2),
        .rdata1_o(rf_rdata1),
        .rdata2_o(rf_rdata2)
    );

    assign wb_we_o    = ex_we;
    assign wb_waddr_o = ex_waddr;
    assign wb_wdata_o = ex_wdata;

endmodule

/* logic/exu.sv */
//**************************************************************************
// execute unit
// forwards from the writeback register, runs the alu, resolves branches
// and jumps, and registers the result for writeback
//**************************************************************************
`timescale 1ns/1ps

module exu (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                id_valid_i,
    input  core_pkg::xlen_t     id_pc_i,
    input  core_pkg::reg_addr_t id_rs1_i,
    input  core_pkg::reg_addr_t id_rs2_i,
    input  core_pkg::xlen_t     id_rs1_data_i,
    input  core_pkg::xlen_t     id_rs2_data_i,
    input  core_pkg::xlen_t     id_imm_i,
    input  logic                id_use_imm_i,
    input  core_pkg::alu_op_e   id_alu_op_i,
    input  core_pkg::br_kind_e  id_br_kind_i,
    input  core_pkg::reg_addr_t id_rd_i,
    input  logic                id_rd_we_i,
    output logic                jump_o,
    output core_pkg::xlen_t     jump_addr_o,
    output logic                wb_we_o,
    output core_pkg::reg_addr_t wb_waddr_o,
    output core_pkg::xlen_t     wb_wdata_o
);

    import core_pkg::*;

    xlen_t op_a;
    xlen_t rs2_val;
    xlen_t op_b;
    xlen_t alu_res;
    xlen_t link_addr;
    logic  is_link;
    logic  br_eq;
    logic  br_lt;
    logic  taken;

    // previous instruction sits in the writeback register
    assign op_a    = (wb_we_o && (wb_waddr_o == id_rs1_i)) ? wb_wdata_o : id_rs1_data_i;
    assign rs2_val = (wb_we_o && (wb_waddr_o == id_rs2_i)) ? wb_wdata_o : id_rs2_data_i;
    assign op_b    = id_use_imm_i ? id_imm_i : rs2_val;

    always_comb begin
        case (id_alu_op_i)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLL:    alu_res = op_a << op_b[4:0];
            ALU_SRL:    alu_res = op_a >> op_b[4:0];
            ALU_SRA:    alu_res = $signed(op_a) >>> op_b[4:0];
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    assign br_eq = (op_a == rs2_val);
    assign br_lt = ($signed(op_a) < $signed(rs2_val));

    always_comb begin
        case (id_br_kind_i)
            BR_BEQ:  taken = br_eq;
            BR_BNE:  taken = ~br_eq;
            BR_BLT:  taken = br_lt;
            BR_BGE:  taken = ~br_lt;
            BR_JAL,
            BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign jump_o      = id_valid_i & taken;
    assign jump_addr_o = (id_br_kind_i == BR_JALR) ? ((op_a + id_imm_i) & ~xlen_t'(1))
                                                   : (id_pc_i + id_imm_i);

    assign is_link   = (id_br_kind_i == BR_JAL) || (id_br_kind_i == BR_JALR);
    assign link_addr = id_pc_i + XLEN'(4);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_we_o <= 1'b0;
        end else begin
            wb_we_o <= id_valid_i & id_rd_we_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_waddr_o <= id_rd_i;
        wb_wdata_o <= is_link ? link_addr : alu_res;  // jal and jalr write pc+4
    end

endmodule

/* logic/idu.sv */
//**************************************************************************
// instruction decode unit
// decodes the returned word, builds the immediate, reads the register file
// and loads the decode/execute register, with a bubble on a flush
//**************************************************************************
`timescale 1ns/1ps

module idu (
    input  logic                clk,
    input  logic                arst_n_i,
    input  core_pkg::inst_u     inst_i,
    input  core_pkg::xlen_t     inst_pc_i,
    input  logic                inst_valid_i,
    input  logic                jump_i,
    input  core_pkg::xlen_t     rs1_rdata_i,
    input  core_pkg::xlen_t     rs2_rdata_i,
    output core_pkg::reg_addr_t rs1_raddr_o,
    output core_pkg::reg_addr_t rs2_raddr_o,
    output logic                id_valid_o,
    output core_pkg::xlen_t     id_pc_o,
    output core_pkg::reg_addr_t id_rs1_o,
    output core_pkg::reg_addr_t id_rs2_o,
    output core_pkg::xlen_t     id_rs1_data_o,
    output core_pkg::xlen_t     id_rs2_data_o,
    output core_pkg::xlen_t     id_imm_o,
    output logic                id_use_imm_o,
    output core_pkg::alu_op_e   id_alu_op_o,
    output core_pkg::br_kind_e  id_br_kind_o,
    output core_pkg::reg_addr_t id_rd_o,
    output logic                id_rd_we_o
);

    import core_pkg::*;

    logic     take;
    inst_u    dec;    // word after bubble insertion
    xlen_t    dec_w;  // same word, raw bits
    xlen_t    imm;
    logic     use_imm;
    alu_op_e  alu_op;
    br_kind_e br_kind;
    logic     rd_we;

    assign take  = inst_valid_i & ~jump_i;
    assign dec   = take ? inst_i : inst_u'(INST_NOP);
    assign dec_w = dec;

    assign rs1_raddr_o = dec.r.rs1;
    assign rs2_raddr_o = dec.r.rs2;

    always_comb begin
        imm     = {{20{dec.i.imm[11]}}, dec.i.imm};  // I form unless overridden
        use_imm = 1'b0;
        alu_op  = ALU_ADD;
        br_kind = BR_NONE;
        rd_we   = 1'b0;
        case (dec.r.opcode)
            OPC_OP: begin
                rd_we = 1'b1;
                case (dec.r.funct3)
                    3'b000:  alu_op = dec.r.funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b001:  alu_op = ALU_SLL;
                    3'b010:  alu_op = ALU_SLT;
                    3'b100:  alu_op = ALU_XOR;
                    3'b101:  alu_op = dec.r.funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: rd_we = 1'b0;  // sltu not supported
                endcase
            end
            OPC_OP_IMM: begin
                rd_we   = 1'b1;
                use_imm = 1'b1;
                case (dec.i.funct3)
                    3'b000:  alu_op = ALU_ADD;
                    3'b001:  alu_op = ALU_SLL;
                    3'b010:  alu_op = ALU_SLT;
                    3'b100:  alu_op = ALU_XOR;
                    3'b101:  alu_op = dec.i.imm[10] ? ALU_SRA : ALU_SRL;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: rd_we = 1'b0;
                endcase
            end
            OPC_LUI: begin
                rd_we   = 1'b1;
                use_imm = 1'b1;
                alu_op  = ALU_PASS_B;
                imm     = {dec_w[31:12], 12'b0};
            end
            OPC_JAL: begin
                rd_we   = 1'b1;
                br_kind = BR_JAL;
                imm     = {{12{dec_w[31]}}, dec_w[19:12], dec_w[20], dec_w[30:21], 1'b0};
            end
            OPC_JALR: begin
                rd_we   = 1'b1;
                br_kind = BR_JALR;
            end
            OPC_BRANCH: begin
                imm = {{20{dec_w[31]}}, dec_w[7], dec_w[30:25], dec_w[11:8], 1'b0};
                case (dec.r.funct3)
                    3'b000:  br_kind = BR_BEQ;
                    3'b001:  br_kind = BR_BNE;
                    3'b100:  br_kind = BR_BLT;
                    3'b101:  br_kind = BR_BGE;
                    default: br_kind = BR_NONE;  // unsigned compares dropped
                endcase
            end
            default: ;  // retires with no write
        endcase
        if (dec.r.rd == '0) begin
            rd_we = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_valid_o   <= 1'b0;
            id_rd_we_o   <= 1'b0;
            id_br_kind_o <= BR_NONE;
        end else begin
            id_valid_o   <= take;
            id_rd_we_o   <= rd_we;
            id_br_kind_o <= br_kind;
        end
    end

    always_ff @(posedge clk) begin
        id_pc_o       <= inst_pc_i;
        id_rs1_o      <= dec.r.rs1;
        id_rs2_o      <= dec.r.rs2;
        id_rs1_data_o <= rs1_rdata_i;
        id_rs2_data_o <= rs2_rdata_i;
        id_imm_o      <= imm;
        id_use_imm_o  <= use_imm;
        id_alu_op_o   <= alu_op;
        id_rd_o       <= dec.r.rd;
    end

endmodule

/* logic/gpr.sv */
//**************************************************************************
// general purpose register file
// x1 to x31 with one write and two combinational read ports, x0 reads as
// zero and a read of the register being written returns the new value
//**************************************************************************
`timescale 1ns/1ps

module gpr (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                we_i,
    input  core_pkg::reg_addr_t waddr_i,
    input  core_pkg::xlen_t     wdata_i,
    input  core_pkg::reg_addr_t raddr1_i,
    input  core_pkg::reg_addr_t raddr2_i,
    output core_pkg::xlen_t     rdata1_o,
    output core_pkg::xlen_t     rdata2_o
);

    import core_pkg::*;

    xlen_t regs_q [1:31];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int k = 1; k < 32; k++) begin
                regs_q[k] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // write-through covers the instruction two ahead in the pipe
    assign rdata1_o = (raddr1_i == '0) ? '0 :
                      (we_i && (waddr_i == raddr1_i)) ? wdata_i : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 :
                      (we_i && (waddr_i == raddr2_i)) ? wdata_i : regs_q[raddr2_i];

endmodule

/* logic/ifu.sv */
//**************************************************************************
// instruction fetch unit
// holds the pc, issues one fetch per cycle on the synchronous instruction
// port and drops the word still in flight when a jump redirects the pc
//**************************************************************************
`timescale 1ns/1ps

module ifu #(
    parameter core_pkg::xlen_t RESET_ADDR = '0
) (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            jump_i,
    input  core_pkg::xlen_t jump_addr_i,
    output core_pkg::xlen_t inst_addr_o,
    output core_pkg::xlen_t inst_pc_o,
    output logic            inst_valid_o
);

    import core_pkg::*;

    xlen_t pc_q;
    xlen_t inst_pc_q;  // address of the word now returning
    logic  fetch_q;    // a request went out last cycle
    logic  drop_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q    <= RESET_ADDR;
            fetch_q <= 1'b0;
            drop_q  <= 1'b0;
        end else begin
            if (jump_i) begin
                pc_q <= jump_addr_i;
            end else begin
                pc_q <= pc_q + XLEN'(4);
            end
            fetch_q <= 1'b1;
            drop_q  <= jump_i;  // word fetched this cycle is wrong path
        end
    end

    always_ff @(posedge clk) begin
        inst_pc_q <= pc_q;
    end

    assign inst_addr_o  = pc_q;
    assign inst_pc_o    = inst_pc_q;
    assign inst_valid_o = fetch_q & ~drop_q;

endmodule

/* logic/core_pkg.sv */
//**************************************************************************
// core package
// shared widths, opcode constants and decode types of the rv32i pipeline,
// including the two-view instruction word used by decode
//**************************************************************************
package core_pkg;

    parameter int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_addr_t;

    // one instruction word, read as R type or as I type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            reg_addr_t  rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            reg_addr_t   rs1;
            logic [2:0]  funct3;
            reg_addr_t   rd;
            logic [6:0]  opcode;
        } i;
    } inst_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_PASS_B  // lui
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_JAL, BR_JALR
    } br_kind_e;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam xlen_t INST_NOP = 32'h0000_0013;  // addi x0, x0, 0

endpackage
